/* hw/rv_defs.svh */
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath width
`define RV_XLEN 32

// Register file address width, 32 registers
`define RV_REG_AW 5

// Instruction memory, word addressed
`define RV_IMEM_WORDS 64
`define RV_IMEM_AW 6

// Data memory, word addressed
`define RV_DMEM_WORDS 64
`define RV_DMEM_AW 6

`endif

/* hw/rv_isa_pkg.sv */
package rv_isa_pkg;

  // Major opcodes from instr[6:0]
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    // LUI passes the U immediate straight through
    ALU_PASS_B
  } alu_op_e;

  // Writeback source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } result_src_e;

  // funct3 for register and immediate ALU ops
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  // LW and SW share the word size code
  localparam logic [2:0] F3_WORD = 3'b010;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

endpackage

/* hw/rv_pipe_pkg.sv */
`include "rv_defs.svh"

package rv_pipe_pkg;

  // Control word produced by decode
  typedef struct packed {
    logic                    reg_write;
    logic                    mem_write;
    logic                    mem_read;
    logic                    branch;
    // Set for BNE, inverts the equality test
    logic                    branch_ne;
    logic                    jump;
    logic                    alu_src_imm;
    rv_isa_pkg::alu_op_e     alu_op;
    rv_isa_pkg::result_src_e result_src;
  } dec_ctrl_t;

  // Execute to memory stage register
  typedef struct packed {
    logic                    valid;
    logic                    reg_write;
    logic                    mem_write;
    logic                    mem_read;
    rv_isa_pkg::result_src_e result_src;
    logic [`RV_REG_AW-1:0]   rd;
    logic [`RV_XLEN-1:0]     alu_result;
    logic [`RV_XLEN-1:0]     store_data;
    logic [`RV_XLEN-1:0]     pc_plus4;
  } ex_mem_t;

endpackage

/* hw/rv_stage_if.sv */
`include "rv_defs.svh"

interface fetch_dec_if;
  logic [`RV_XLEN-1:0] instr;
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] pc_plus4;
  logic                valid;
  // Held high by decode during a load-use hazard
  logic                stall;

  modport src  (output instr, pc, pc_plus4, valid, input stall);
  modport sink (input instr, pc, pc_plus4, valid, output stall);
endinterface

interface redirect_if;
  logic                take;
  logic [`RV_XLEN-1:0] target;
  logic                flush;

  modport src  (output take, target, flush);
  modport sink (input take, target, flush);
endinterface

interface dec_ex_if;
  import rv_pipe_pkg::*;

  logic                  valid;
  dec_ctrl_t             ctrl;
  logic [`RV_REG_AW-1:0] rs1;
  logic [`RV_REG_AW-1:0] rs2;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   imm;
  logic [`RV_XLEN-1:0]   pc;
  logic [`RV_XLEN-1:0]   pc_plus4;
  // Sources of the instruction still in decode, for load-use detection
  logic [`RV_REG_AW-1:0] dec_rs1;
  logic [`RV_REG_AW-1:0] dec_rs2;

  modport src  (output valid, ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm, pc, pc_plus4,
                dec_rs1, dec_rs2);
  modport sink (input valid, ctrl, rs1, rs2, rd, rs1_data, rs2_data, imm, pc, pc_plus4,
                dec_rs1, dec_rs2);
endinterface

interface wb_if;
  logic                  we;
  logic [`RV_REG_AW-1:0] rd;
  logic [`RV_XLEN-1:0]   data;

  modport src  (output we, rd, data);
  modport sink (input we, rd, data);
endinterface

/* hw/rv_fetch.sv */
`include "rv_defs.svh"

module rv_fetch (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   prog_we,
  input  logic [`RV_IMEM_AW-1:0] prog_addr,
  input  logic [`RV_XLEN-1:0]    prog_data,
  fetch_dec_if.src               fd,
  redirect_if.sink               rd
);

  logic [`RV_XLEN-1:0]    imem [`RV_IMEM_WORDS];
  logic [`RV_XLEN-1:0]    pc_q;
  logic [`RV_XLEN-1:0]    pc_next4;
  logic [`RV_IMEM_AW-1:0] imem_idx;

  assign pc_next4 = pc_q + 'd4;
  assign imem_idx = pc_q[`RV_IMEM_AW+1:2];

  // Program loading only happens with the core held in reset
  always_ff @(posedge clk) begin
    if (prog_we && !rst_n) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // Redirect wins over a load-use stall
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= '0;
    end else if (rd.take) begin
      pc_q <= rd.target;
    end else if (!fd.stall) begin
      pc_q <= pc_next4;
    end
  end

  // Fetch to decode valid bit
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fd.valid <= 1'b0;
    end else if (rd.flush) begin
      fd.valid <= 1'b0;
    end else if (!fd.stall) begin
      fd.valid <= 1'b1;
    end
  end

  // Instruction payload, held while stalled
  always_ff @(posedge clk) begin
    if (!fd.stall) begin
      fd.instr    <= imem[imem_idx];
      fd.pc       <= pc_q;
      fd.pc_plus4 <= pc_next4;
    end
  end

  // Program port must stay quiet once the core runs
  a_prog_only_in_reset: assert property (
    @(posedge clk) prog_we |-> !rst_n
  );

endmodule

/* hw/rv_decode.sv */
`include "rv_defs.svh"

module rv_decode (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load_use_stall,
  fetch_dec_if.sink           fd,
  redirect_if.sink            rd,
  wb_if.sink                  wb,
  dec_ex_if.src               de,
  output logic [`RV_XLEN-1:0] a0
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  localparam int A0_IDX = 10;

  logic [`RV_XLEN-1:0]   regs [2**`RV_REG_AW];
  opcode_e               opcode;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic [`RV_REG_AW-1:0] rs1_addr;
  logic [`RV_REG_AW-1:0] rs2_addr;
  logic [`RV_REG_AW-1:0] rd_addr;
  logic [`RV_XLEN-1:0]   rs1_val;
  logic [`RV_XLEN-1:0]   rs2_val;
  logic [`RV_XLEN-1:0]   imm;
  dec_ctrl_t             ctrl;
  logic                  supported;
  logic                  issue;
  alu_op_e               f3_alu;
  logic                  f3_ok;

  assign opcode   = opcode_e'(fd.instr[6:0]);
  assign funct3   = fd.instr[14:12];
  assign funct7   = fd.instr[31:25];
  assign rs1_addr = fd.instr[19:15];
  assign rs2_addr = fd.instr[24:20];
  assign rd_addr  = fd.instr[11:7];

  // ALU op shared by OP and OP-IMM
  always_comb begin
    f3_alu = ALU_ADD;
    f3_ok  = 1'b1;
    case (funct3)
      F3_ADD:  f3_alu = ALU_ADD;
      F3_SLT:  f3_alu = ALU_SLT;
      F3_XOR:  f3_alu = ALU_XOR;
      F3_OR:   f3_alu = ALU_OR;
      F3_AND:  f3_alu = ALU_AND;
      default: f3_ok  = 1'b0;
    endcase
  end

  // Control word and immediate per format
  always_comb begin
    ctrl      = '0;
    imm       = '0;
    supported = 1'b1;
    case (opcode)
      OPC_OP_IMM: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = f3_alu;
        imm              = {{20{fd.instr[31]}}, fd.instr[31:20]};
        supported        = f3_ok;
      end
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = (funct7 == 7'b0100000) ? ALU_SUB : f3_alu;
        supported      = f3_ok && (funct7 == 7'b0000000 ||
                                   (funct7 == 7'b0100000 && funct3 == F3_ADD));
      end
      OPC_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_PASS_B;
        imm              = {fd.instr[31:12], 12'b0};
      end
      OPC_LOAD: begin
        ctrl.reg_write   = 1'b1;
        ctrl.mem_read    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.result_src  = RES_MEM;
        imm              = {{20{fd.instr[31]}}, fd.instr[31:20]};
        supported        = (funct3 == F3_WORD);
      end
      OPC_STORE: begin
        ctrl.mem_write   = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        imm              = {{20{fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
        supported        = (funct3 == F3_WORD);
      end
      OPC_BRANCH: begin
        ctrl.branch    = 1'b1;
        ctrl.branch_ne = (funct3 == F3_BNE);
        imm            = {{19{fd.instr[31]}}, fd.instr[31], fd.instr[7],
                          fd.instr[30:25], fd.instr[11:8], 1'b0};
        supported      = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
      end
      OPC_JAL: begin
        ctrl.reg_write  = 1'b1;
        ctrl.jump       = 1'b1;
        ctrl.result_src = RES_PC4;
        imm             = {{11{fd.instr[31]}}, fd.instr[31], fd.instr[19:12],
                           fd.instr[20], fd.instr[30:21], 1'b0};
      end
      default: supported = 1'b0;
    endcase
  end

  // Register file, x0 never written
  always_ff @(posedge clk) begin
    if (wb.we && wb.rd != '0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  // Same-cycle writeback is bypassed into the read
  assign rs1_val = (rs1_addr == '0) ? '0 :
                   (wb.we && wb.rd == rs1_addr) ? wb.data : regs[rs1_addr];
  assign rs2_val = (rs2_addr == '0) ? '0 :
                   (wb.we && wb.rd == rs2_addr) ? wb.data : regs[rs2_addr];

  assign a0         = regs[A0_IDX];
  assign fd.stall   = load_use_stall;
  assign de.dec_rs1 = rs1_addr;
  assign de.dec_rs2 = rs2_addr;

  // Bubble on flush, stall or unsupported encoding
  assign issue = fd.valid && supported && !rd.flush && !load_use_stall;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      de.valid <= 1'b0;
      de.ctrl  <= '0;
    end else begin
      de.valid <= issue;
      de.ctrl  <= issue ? ctrl : '0;
    end
  end

  always_ff @(posedge clk) begin
    de.rs1      <= rs1_addr;
    de.rs2      <= rs2_addr;
    de.rd       <= rd_addr;
    de.rs1_data <= rs1_val;
    de.rs2_data <= rs2_val;
    de.imm      <= imm;
    de.pc       <= fd.pc;
    de.pc_plus4 <= fd.pc_plus4;
  end

  // A write aimed at x0 is dropped and leaves the stored registers as they were
  a_x0_write_dropped: assert property (
    @(posedge clk) disable iff (!rst_n)
    (wb.we && wb.rd == '0) |=> $stable(a0)
  );

endmodule

/* hw/rv_execute.sv */
`include "rv_defs.svh"

module rv_execute (
  input  logic                 clk,
  input  logic                 rst_n,
  dec_ex_if.sink               de,
  wb_if.sink                   wb,
  redirect_if.src              rd,
  output logic                 load_use_stall,
  output rv_pipe_pkg::ex_mem_t exm
);
  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic                mem_fwd_ok;
  logic [`RV_XLEN-1:0] mem_fwd_data;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] fwd_b;
  logic [`RV_XLEN-1:0] op_b;
  logic [`RV_XLEN-1:0] alu_y;
  logic                equal;
  logic                taken;
  ex_mem_t             exm_d;

  // Memory stage first, then writeback, else the register file value
  function automatic logic [`RV_XLEN-1:0] pick_operand(
    input logic [`RV_REG_AW-1:0] rs,
    input logic [`RV_XLEN-1:0]   reg_data,
    input logic                  m_ok,
    input logic [`RV_REG_AW-1:0] m_rd,
    input logic [`RV_XLEN-1:0]   m_data,
    input logic                  w_ok,
    input logic [`RV_REG_AW-1:0] w_rd,
    input logic [`RV_XLEN-1:0]   w_data
  );
    if (rs == '0) return reg_data;
    if (m_ok && m_rd == rs) return m_data;
    if (w_ok && w_rd == rs) return w_data;
    return reg_data;
  endfunction

  // Load data is not ready until writeback
  assign mem_fwd_ok   = exm.valid && exm.reg_write && !exm.mem_read;
  assign mem_fwd_data = (exm.result_src == RES_PC4) ? exm.pc_plus4 : exm.alu_result;

  assign op_a  = pick_operand(de.rs1, de.rs1_data, mem_fwd_ok, exm.rd, mem_fwd_data,
                              wb.we, wb.rd, wb.data);
  assign fwd_b = pick_operand(de.rs2, de.rs2_data, mem_fwd_ok, exm.rd, mem_fwd_data,
                              wb.we, wb.rd, wb.data);
  assign op_b  = de.ctrl.alu_src_imm ? de.imm : fwd_b;

  always_comb begin
    case (de.ctrl.alu_op)
      ALU_ADD:    alu_y = op_a + op_b;
      ALU_SUB:    alu_y = op_a - op_b;
      ALU_AND:    alu_y = op_a & op_b;
      ALU_OR:     alu_y = op_a | op_b;
      ALU_XOR:    alu_y = op_a ^ op_b;
      ALU_SLT:    alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_PASS_B: alu_y = op_b;
      default:    alu_y = op_a + op_b;
    endcase
  end

  // Branch and jump resolution
  assign equal     = (op_a == fwd_b);
  assign taken     = de.valid && (de.ctrl.jump ||
                                  (de.ctrl.branch && (equal ^ de.ctrl.branch_ne)));
  assign rd.take   = taken;
  assign rd.flush  = taken;
  assign rd.target = de.pc + de.imm;

  // load in execute, dependent instruction one behind in decode
  assign load_use_stall = de.valid && de.ctrl.mem_read && de.rd != '0 &&
                          (de.rd == de.dec_rs1 || de.rd == de.dec_rs2);

  always_comb begin
    exm_d.valid      = de.valid;
    exm_d.reg_write  = de.ctrl.reg_write;
    exm_d.mem_write  = de.ctrl.mem_write;
    exm_d.mem_read   = de.ctrl.mem_read;
    exm_d.result_src = de.ctrl.result_src;
    exm_d.rd         = de.rd;
    exm_d.alu_result = alu_y;
    exm_d.store_data = fwd_b;
    exm_d.pc_plus4   = de.pc_plus4;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exm <= '0;
    end else begin
      exm <= exm_d;
    end
  end

endmodule

/* hw/rv_mem_wb.sv */
`include "rv_defs.svh"

module rv_mem_wb (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_pipe_pkg::ex_mem_t exm,
  wb_if.src                    wb,
  output logic                 retire
);
  import rv_isa_pkg::*;

  logic [`RV_XLEN-1:0]    dmem [`RV_DMEM_WORDS];
  logic [`RV_DMEM_AW-1:0] dmem_idx;
  logic [`RV_XLEN-1:0]    load_data;
  logic                   wb_valid;
  logic                   wb_reg_write;
  result_src_e            wb_src;
  logic [`RV_REG_AW-1:0]  wb_rd;
  logic [`RV_XLEN-1:0]    wb_alu;
  logic [`RV_XLEN-1:0]    wb_load;
  logic [`RV_XLEN-1:0]    wb_pc4;

  // Word index from the byte address
  assign dmem_idx  = exm.alu_result[`RV_DMEM_AW+1:2];
  assign load_data = dmem[dmem_idx];

  always_ff @(posedge clk) begin
    if (exm.valid && exm.mem_write) begin
      dmem[dmem_idx] <= exm.store_data;
    end
  end

  // Memory to writeback register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid     <= 1'b0;
      wb_reg_write <= 1'b0;
      wb_src       <= RES_ALU;
    end else begin
      wb_valid     <= exm.valid;
      wb_reg_write <= exm.valid && exm.reg_write;
      wb_src       <= exm.result_src;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= exm.rd;
    wb_alu  <= exm.alu_result;
    wb_load <= load_data;
    wb_pc4  <= exm.pc_plus4;
  end

  assign wb.we   = wb_valid && wb_reg_write;
  assign wb.rd   = wb_rd;
  assign wb.data = (wb_src == RES_MEM) ? wb_load :
                   (wb_src == RES_PC4) ? wb_pc4 : wb_alu;
  assign retire  = wb_valid;

  // Only word accesses exist
  a_store_aligned: assert property (
    @(posedge clk) disable iff (!rst_n)
    (exm.valid && exm.mem_write) |-> (exm.alu_result[1:0] == 2'b00)
  );

endmodule

/* hw/rv_core_top.sv */
`include "rv_defs.svh"

module rv_core_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   prog_we,
  input  logic [`RV_IMEM_AW-1:0] prog_addr,
  input  logic [`RV_XLEN-1:0]    prog_data,
  output logic [`RV_XLEN-1:0]    a0,
  output logic                   retire
);
  import rv_pipe_pkg::*;

  fetch_dec_if fd_bus ();
  redirect_if  redir_bus ();
  dec_ex_if    de_bus ();
  wb_if        wb_bus ();

  ex_mem_t exm;
  logic    load_use_stall;

  rv_fetch u_fetch (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .fd        (fd_bus.src),
    .rd        (redir_bus.sink)
  );

  rv_decode u_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .load_use_stall (load_use_stall),
    .fd             (fd_bus.sink),
    .rd             (redir_bus.sink),
    .wb             (wb_bus.sink),
    .de             (de_bus.src),
    .a0             (a0)
  );

  rv_execute u_execute (
    .clk            (clk),
    .rst_n          (rst_n),
    .de             (de_bus.sink),
    .wb             (wb_bus.sink),
    .rd             (redir_bus.src),
    .load_use_stall (load_use_stall),
    .exm            (exm)
  );

  rv_mem_wb u_mem_wb (
    .clk    (clk),
    .rst_n  (rst_n),
    .exm    (exm),
    .wb     (wb_bus.src),
    .retire (retire)
  );

endmodule

/* testbench/tb_clk_gen.sv */
module tb_clk_gen #(
  parameter int HALF_PERIOD = 2
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

endmodule

/* testbench/tb_rv_core.sv */
`include "rv_defs.svh"

module tb_rv_core;

  localparam int MAX_TESTS      = 24;
  localparam int MAX_WORDS      = 16;
  localparam int RESET_CYCLES   = 8;
  localparam int RETIRE_TIMEOUT = 200;
  localparam int SETTLE_CYCLES  = 6;
  // Self-loop JAL passes in the settle window, each pass takes 3 cycles
  localparam int LOOP_RETIRES   = 2;
  localparam logic [4:0] A0     = 5'd10;

  // RV32I funct3 and funct7 codes
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [6:0] F7_SUB = 7'b0100000;

  logic                   clk;
  logic                   rst_n;
  logic                   prog_we;
  logic [`RV_IMEM_AW-1:0] prog_addr;
  logic [`RV_XLEN-1:0]    prog_data;
  logic [`RV_XLEN-1:0]    a0;
  logic                   retire;

  // Table of programs and expected results
  logic [31:0] t_prog   [MAX_TESTS][MAX_WORDS];
  int          t_len    [MAX_TESTS];
  string       t_name   [MAX_TESTS];
  int          t_retire [MAX_TESTS];
  logic [31:0] t_expect [MAX_TESTS];
  int          n_tests;
  logic [31:0] prog [$];
  int          seed;
  int          t;

  tb_clk_gen u_clk_gen (
    .clk (clk)
  );

  rv_core_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .a0        (a0),
    .retire    (retire)
  );

  function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] reg_op(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, 7'b0110111};
  endfunction

  function automatic logic [31:0] lw(input logic [4:0] rd, input logic [4:0] rs1,
                                     input logic [11:0] off);
    return {off, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input logic [4:0] rs2, input logic [4:0] rs1,
                                     input logic [11:0] off);
    return {off[11:5], rs2, rs1, 3'b010, off[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  // Unused slots get an illegal opcode tagged with their address
  function automatic logic [31:0] fill_word(input logic [`RV_IMEM_AW-1:0] addr);
    return {{(32 - `RV_IMEM_AW - 7){1'b0}}, addr, 7'h7f};
  endfunction

  // RV32I result of the register and immediate ALU ops
  function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic [31:0] x,
                                          input logic [31:0] y);
    case (f3)
      F3_ADD:  return x + y;
      F3_SLT:  return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
      F3_XOR:  return x ^ y;
      F3_OR:   return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  // Closes the program in prog with a self-loop and stores the entry
  task automatic add_test(input string name, input int retires,
                          input logic [31:0] expect_a0);
    int i;
    prog.push_back(jal(5'd0, 21'd0));
    for (i = 0; i < prog.size(); i++) begin
      t_prog[n_tests][i] = prog[i];
    end
    t_len[n_tests]    = prog.size();
    t_name[n_tests]   = name;
    t_retire[n_tests] = retires;
    t_expect[n_tests] = expect_a0;
    n_tests++;
    prog.delete();
  endtask

  task automatic build_table();
    logic [31:0] hi_a;
    logic [31:0] lo_a;
    logic [31:0] hi_b;
    logic [31:0] lo_b;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expect_a0;
    logic [2:0]  f3_list [5];
    string       op_names [12];
    int          k;

    f3_list  = '{F3_ADD, F3_AND, F3_OR, F3_XOR, F3_SLT};
    op_names = '{"addi", "andi", "ori", "xori", "slti",
                 "add", "and", "or", "xor", "slt", "sub", "lui"};

    // One ALU op per entry, operands built with LUI and ADDI
    for (k = 0; k < 12; k++) begin
      hi_a = $random(seed);
      lo_a = $random(seed);
      hi_b = $random(seed);
      lo_b = $random(seed);
      imm  = $random(seed);
      a    = {hi_a[19:0], 12'b0} + sext12(lo_a[11:0]);
      b    = {hi_b[19:0], 12'b0} + sext12(lo_b[11:0]);
      prog.push_back(lui(5'd1, hi_a[19:0]));
      prog.push_back(imm_op(F3_ADD, 5'd1, 5'd1, lo_a[11:0]));
      prog.push_back(lui(5'd2, hi_b[19:0]));
      prog.push_back(imm_op(F3_ADD, 5'd2, 5'd2, lo_b[11:0]));
      if (k < 5) begin
        prog.push_back(imm_op(f3_list[k], A0, 5'd1, imm[11:0]));
        expect_a0 = alu_ref(f3_list[k], a, sext12(imm[11:0]));
      end else if (k < 10) begin
        prog.push_back(reg_op(7'b0, f3_list[k-5], A0, 5'd1, 5'd2));
        expect_a0 = alu_ref(f3_list[k-5], a, b);
      end else if (k == 10) begin
        prog.push_back(reg_op(F7_SUB, F3_ADD, A0, 5'd1, 5'd2));
        expect_a0 = a - b;
      end else begin
        prog.push_back(lui(A0, imm[31:12]));
        expect_a0 = {imm[31:12], 12'b0};
      end
      add_test(op_names[k], 5, expect_a0);
    end

    // Signed compare of a negative value, then a signed overflow
    prog.push_back(lui(5'd1, 20'hfffff));
    prog.push_back(imm_op(F3_ADD, 5'd2, 5'd0, 12'd1));
    prog.push_back(reg_op(7'b0, F3_SLT, 5'd4, 5'd1, 5'd2));
    prog.push_back(lui(5'd3, 20'h80000));
    prog.push_back(imm_op(F3_ADD, 5'd3, 5'd3, 12'hfff));
    prog.push_back(reg_op(7'b0, F3_ADD, A0, 5'd3, 5'd4));
    add_test("wrap_slt", 6, 32'h8000_0000);

    // Dependent chain, 3 6 9 3 10 then 110
    prog.push_back(imm_op(F3_ADD, 5'd5, 5'd0, 12'd3));
    prog.push_back(reg_op(7'b0, F3_ADD, 5'd6, 5'd5, 5'd5));
    prog.push_back(reg_op(7'b0, F3_ADD, 5'd7, 5'd6, 5'd5));
    prog.push_back(reg_op(F7_SUB, F3_ADD, 5'd8, 5'd7, 5'd6));
    prog.push_back(reg_op(7'b0, F3_XOR, A0, 5'd8, 5'd7));
    prog.push_back(imm_op(F3_ADD, A0, A0, 12'd100));
    add_test("fwd_chain", 6, 32'd110);

    // Store, load back, use at once
    prog.push_back(imm_op(F3_ADD, 5'd1, 5'd0, 12'h123));
    prog.push_back(imm_op(F3_ADD, 5'd2, 5'd0, 12'd8));
    prog.push_back(sw(5'd1, 5'd2, 12'd0));
    prog.push_back(lw(5'd3, 5'd2, 12'd0));
    prog.push_back(reg_op(7'b0, F3_ADD, A0, 5'd3, 5'd1));
    add_test("sw_lw_use", 5, 32'h246);

    // BEQ taken over two poisoned ADDIs, BNE not taken
    prog.push_back(imm_op(F3_ADD, 5'd1, 5'd0, 12'd5));
    prog.push_back(imm_op(F3_ADD, 5'd2, 5'd0, 12'd5));
    prog.push_back(imm_op(F3_ADD, A0, 5'd0, 12'd1));
    prog.push_back(branch(F3_BEQ, 5'd1, 5'd2, 13'd12));
    prog.push_back(imm_op(F3_ADD, A0, A0, 12'd100));
    prog.push_back(imm_op(F3_ADD, A0, A0, 12'd100));
    prog.push_back(branch(F3_BNE, 5'd1, 5'd2, 13'd8));
    prog.push_back(imm_op(F3_ADD, A0, A0, 12'd6));
    add_test("branches", 6, 32'd7);

    // JAL from pc 4 to pc 16, link value 8
    prog.push_back(imm_op(F3_ADD, A0, 5'd0, 12'd77));
    prog.push_back(jal(A0, 21'd12));
    prog.push_back(imm_op(F3_ADD, A0, 5'd0, 12'hfff));
    prog.push_back(imm_op(F3_ADD, A0, 5'd0, 12'hfff));
    prog.push_back(imm_op(F3_ADD, A0, A0, 12'd16));
    add_test("jal_link", 3, 32'd24);

    // Sum 1 to 10, three setup ops and ten passes of three
    prog.push_back(imm_op(F3_ADD, A0, 5'd0, 12'd0));
    prog.push_back(imm_op(F3_ADD, 5'd1, 5'd0, 12'd1));
    prog.push_back(imm_op(F3_ADD, 5'd2, 5'd0, 12'd11));
    prog.push_back(reg_op(7'b0, F3_ADD, A0, A0, 5'd1));
    prog.push_back(imm_op(F3_ADD, 5'd1, 5'd1, 12'd1));
    prog.push_back(branch(F3_BNE, 5'd1, 5'd2, -13'sd8));
    add_test("sum_loop", 33, 32'd55);
  endtask

  task automatic wait_retires(input int idx);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < t_retire[idx] && cycles < RETIRE_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (retire) begin
        seen++;
      end
    end
    if (seen < t_retire[idx]) begin
      $display("retirement stalled in %s: %0d of %0d instructions retired in %0d cycles",
               t_name[idx], seen, t_retire[idx], cycles);
      $display(">>> FAIL");
      $fatal(1, "retire timeout");
    end
  endtask

  task automatic run_test(input int idx);
    int i;
    int loop_retires;
    @(negedge clk);
    rst_n = 1'b0;
    // The whole instruction memory is rewritten under reset
    for (i = 0; i < `RV_IMEM_WORDS; i++) begin
      @(negedge clk);
      prog_we   = 1'b1;
      prog_addr = i[`RV_IMEM_AW-1:0];
      prog_data = (i < t_len[idx]) ? t_prog[idx][i] : fill_word(i[`RV_IMEM_AW-1:0]);
    end
    @(negedge clk);
    prog_we = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    wait_retires(idx);
    // Only the self-loop JAL retires from here on
    loop_retires = 0;
    for (i = 0; i < SETTLE_CYCLES; i++) begin
      @(negedge clk);
      if (retire) begin
        loop_retires++;
      end
    end
    check_value(t_name[idx], t_expect[idx], a0);
    check_value({t_name[idx], " loop retires"}, LOOP_RETIRES, loop_retires);
  endtask

  initial begin
    rst_n      = 1'b0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    seed       = 92060;
    n_tests    = 0;
    build_table();
    for (t = 0; t < n_tests; t++) begin
      run_test(t);
    end
    $display(">>> PASS");
    $finish;
  end

endmodule

/* tb.f */
+incdir+hw
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_stage_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_mem_wb.sv
hw/rv_core_top.sv
testbench/tb_clk_gen.sv
testbench/tb_rv_core.sv
